// ==== sources.f ====
+incdir+hdl
hdl/axi_burst_pkg.sv
hdl/ram_mem_pkg.sv
hdl/burst_addr_gen.sv
hdl/ram_byte_array.sv
hdl/ram_write_stage.sv
hdl/ram_read_stage.sv
hdl/ram_axi_top.sv
bench/ram_axi_properties.sv
bench/ram_axi_tb.sv

// ==== Bender.yml ====
package:
  name: ram_axi

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axi_burst_pkg.sv
      - hdl/ram_mem_pkg.sv
      - hdl/burst_addr_gen.sv
      - hdl/ram_byte_array.sv
      - hdl/ram_write_stage.sv
      - hdl/ram_read_stage.sv
      - hdl/ram_axi_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/ram_axi_properties.sv
      - bench/ram_axi_tb.sv

// ==== bench/ram_axi_tb.sv ====
/*
 testbench for the AXI4 RAM slave
 LCG driven bursts against a byte-level reference memory
 */
`timescale 1ns/1ps
`include "ram_axi_defines.svh"

module ram_axi_tb
    import axi_burst_pkg::*;
    import ram_mem_pkg::*;
();

    localparam int RESET_CYCLES   = 5;
    localparam int WIN_WORDS      = 64;  // test window, 256 bytes
    localparam int N_FILL         = 4;
    localparam int N_INCR         = 12;
    localparam int N_WRAP         = 8;
    localparam int N_FIXED        = 4;
    localparam int NUM_BURSTS     = N_FILL + 2 * (N_INCR + N_WRAP + N_FIXED);
    localparam int TIMEOUT_CYCLES = 40 * NUM_BURSTS + RESET_CYCLES;

    logic S_AXI_ACLK;
    logic S_AXI_ARESETN;
    axi_id_t s_axi_awid, s_axi_bid, s_axi_arid, s_axi_rid;
    axi_addr_t s_axi_awaddr, s_axi_araddr;
    axi_len_t s_axi_awlen, s_axi_arlen;
    axi_burst_e s_axi_awburst, s_axi_arburst;
    logic s_axi_awvalid, s_axi_awready, s_axi_wlast, s_axi_wvalid, s_axi_wready;
    logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic s_axi_rlast, s_axi_rvalid, s_axi_rready;
    mem_word_u s_axi_wdata, s_axi_rdata;
    strb_t s_axi_wstrb;
    axi_resp_e s_axi_bresp, s_axi_rresp;

    logic [7:0]  ref_mem [4 << `RAM_WORDS_LOG2];  // expected bytes
    logic [31:0] exp_data [$];
    logic        exp_last [$];
    axi_id_t     exp_id [$];
    logic [31:0] lcg_state = 32'd87;
    int          beats_left = 0;
    int          errors = 0;
    int          cycles = 0;

    ram_axi_top uut (.*);

    bind ram_axi_top ram_axi_properties u_props (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_rid     (s_axi_rid),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rlast   (s_axi_rlast),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic axi_id_t rand_id();
        logic [31:0] r;
        r = next_rand();
        return r[31:28];
    endfunction

    // word in the window, upper address bits random since they alias
    function automatic axi_addr_t alias_addr(int word);
        logic [31:0] r;
        r = next_rand();
        return {r[31:28], 12'(word * 4)};
    endfunction

    // word index of beat n, straight from the burst rules
    function automatic word_idx_t ref_beat_idx(axi_addr_t start, axi_len_t len,
                                               axi_burst_e kind, int n);
        int word;
        int size;
        int base;
        word = (int'(start) % (4 << `RAM_WORDS_LOG2)) / 4;
        size = int'(len) + 1;
        case (kind)
            BURST_FIXED: return word_idx_t'(word);
            BURST_WRAP: begin
                base = (word / size) * size;  // block aligned to its size
                return word_idx_t'(base + (word - base + n) % size);
            end
            default: return word_idx_t'((word + n) % (1 << `RAM_WORDS_LOG2));
        endcase
    endfunction

    function automatic logic [31:0] model_word(word_idx_t idx);
        mem_word_u w;
        for (int lane = 0; lane < `AXI_STRB_W; lane++) begin
            w.bytes[lane] = ref_mem[int'(idx) * 4 + lane];
        end
        return w.word;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                               input axi_burst_e kind, input logic full_strb);
        logic [31:0] r;
        mem_word_u   data;
        strb_t       strb;
        word_idx_t   idx;
        @(negedge S_AXI_ACLK);
        s_axi_awid    = id;
        s_axi_awaddr  = addr;
        s_axi_awlen   = len;
        s_axi_awburst = kind;
        s_axi_awvalid = 1'b1;
        do @(posedge S_AXI_ACLK); while (!s_axi_awready);
        @(negedge S_AXI_ACLK);
        s_axi_awvalid = 1'b0;
        for (int n = 0; n <= int'(len); n++) begin
            r = next_rand();
            data.word = next_rand();
            strb = full_strb ? 4'hF : r[27:24];
            if (r[31:30] == 2'b00) begin  // idle cycle on W now and then
                s_axi_wvalid = 1'b0;
                @(negedge S_AXI_ACLK);
            end
            s_axi_wdata  = data;
            s_axi_wstrb  = strb;
            s_axi_wlast  = (n == int'(len));
            s_axi_wvalid = 1'b1;
            do @(posedge S_AXI_ACLK); while (!s_axi_wready);
            idx = ref_beat_idx(addr, len, kind, n);
            for (int lane = 0; lane < `AXI_STRB_W; lane++) begin
                if (strb[lane]) ref_mem[int'(idx) * 4 + lane] = data.bytes[lane];
            end
            @(negedge S_AXI_ACLK);
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
        r = next_rand();
        repeat (r[31:30]) @(negedge S_AXI_ACLK);  // hold off B for a few cycles
        s_axi_bready = 1'b1;
        do @(posedge S_AXI_ACLK); while (!s_axi_bvalid);
        check(32'(s_axi_bid), 32'(id), "bid");
        check(32'(s_axi_bresp), 32'(RESP_OKAY), "bresp");
        @(negedge S_AXI_ACLK);
        s_axi_bready = 1'b0;
    endtask

    task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                              input axi_burst_e kind);
        logic [31:0] r;
        for (int n = 0; n <= int'(len); n++) begin
            exp_data.push_back(model_word(ref_beat_idx(addr, len, kind, n)));
            exp_last.push_back(n == int'(len));
            exp_id.push_back(id);
        end
        beats_left = int'(len) + 1;
        @(negedge S_AXI_ACLK);
        s_axi_arid    = id;
        s_axi_araddr  = addr;
        s_axi_arlen   = len;
        s_axi_arburst = kind;
        s_axi_arvalid = 1'b1;
        do @(posedge S_AXI_ACLK); while (!s_axi_arready);
        @(negedge S_AXI_ACLK);
        s_axi_arvalid = 1'b0;
        while (beats_left != 0) begin
            r = next_rand();
            s_axi_rready = (r[31:30] != 2'b00);  // stall about one cycle in four
            @(negedge S_AXI_ACLK);
        end
        s_axi_rready = 1'b0;
    endtask

    // every R transfer against the model
    always @(posedge S_AXI_ACLK) begin
        if (S_AXI_ARESETN && s_axi_rvalid && s_axi_rready) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("ERROR at %0t ns: R beat arrived with no read outstanding", $time);
            end else begin
                check(s_axi_rdata.word, exp_data.pop_front(), "rdata");
                check(32'(s_axi_rlast), 32'(exp_last.pop_front()), "rlast");
                check(32'(s_axi_rid), 32'(exp_id.pop_front()), "rid");
                check(32'(s_axi_rresp), 32'(RESP_OKAY), "rresp");
                beats_left--;
            end
        end
    end

    always @(posedge S_AXI_ACLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            errors++;
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d", errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int len;
        int word;
        int base;
        {s_axi_awid, s_axi_awaddr, s_axi_awlen, s_axi_awvalid} = '0;
        {s_axi_arid, s_axi_araddr, s_axi_arlen, s_axi_arvalid} = '0;
        s_axi_awburst = BURST_INCR;
        s_axi_arburst = BURST_INCR;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wlast   = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_rready  = 1'b0;
        S_AXI_ARESETN = 1'b0;
        repeat (RESET_CYCLES) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);
        check(32'(s_axi_awready), 32'd1, "awready after reset");
        check(32'(s_axi_arready), 32'd1, "arready after reset");
        check(32'(s_axi_wready), 32'd0, "wready after reset");
        check(32'(s_axi_bvalid), 32'd0, "bvalid after reset");
        check(32'(s_axi_rvalid), 32'd0, "rvalid after reset");

        // known contents in the whole window first
        for (int f = 0; f < N_FILL; f++) begin
            write_burst(rand_id(), axi_addr_t'(f * 64), 8'd15, BURST_INCR, 1'b1);
        end
        for (int i = 0; i < N_INCR; i++) begin
            len  = (next_rand() >> 16) % 16;
            word = (next_rand() >> 16) % (WIN_WORDS - len);
            write_burst(rand_id(), alias_addr(word), axi_len_t'(len), BURST_INCR, 1'b0);
            read_burst(rand_id(), alias_addr(word), axi_len_t'(len), BURST_INCR);
        end
        for (int i = 0; i < N_WRAP; i++) begin
            len  = (1 << (i % 4 + 1)) - 1;  // 1, 3, 7, 15
            word = (next_rand() >> 16) % WIN_WORDS;
            base = (word / (len + 1)) * (len + 1);
            write_burst(rand_id(), alias_addr(word), axi_len_t'(len), BURST_WRAP, 1'b0);
            if (i < 4) begin
                read_burst(rand_id(), alias_addr(word), axi_len_t'(len), BURST_WRAP);
            end else begin
                read_burst(rand_id(), alias_addr(base), axi_len_t'(len), BURST_INCR);
            end
        end
        for (int i = 0; i < N_FIXED; i++) begin
            len  = 1 + (next_rand() >> 16) % 15;
            word = (next_rand() >> 16) % WIN_WORDS;
            write_burst(rand_id(), alias_addr(word), axi_len_t'(len), BURST_FIXED, 1'b0);
            read_burst(rand_id(), alias_addr(word), axi_len_t'(len), BURST_FIXED);
        end

        // both paths back to idle, no stray beat left in the buffer
        repeat (4) @(negedge S_AXI_ACLK);
        check(32'(s_axi_rvalid), 32'd0, "rvalid after the last burst");
        check(32'(s_axi_arready), 32'd1, "arready after the last burst");
        check(32'(s_axi_awready), 32'd1, "awready after the last burst");
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== bench/ram_axi_properties.sv ====
/*
 AXI4 handshake properties on the RAM slave ports
 */
`timescale 1ns/1ps
`include "ram_axi_defines.svh"

module ram_axi_properties (
    input logic                  S_AXI_ACLK,
    input logic                  S_AXI_ARESETN,
    input logic                  s_axi_wready,
    input logic                  s_axi_bvalid,
    input logic                  s_axi_bready,
    input logic [`AXI_ID_W-1:0]  s_axi_rid,
    input logic [`AXI_DATA_W-1:0] s_axi_rdata,
    input logic                  s_axi_rlast,
    input logic                  s_axi_rvalid,
    input logic                  s_axi_rready
);

    // valid stays up until taken
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
        else $error("rvalid dropped before the beat was accepted");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before the response was accepted");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=>
            $stable(s_axi_rdata) && $stable(s_axi_rid) && $stable(s_axi_rlast))
        else $error("R payload changed while stalled");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_wready && s_axi_bvalid))
        else $error("wready and bvalid high together");

endmodule

// ==== hdl/ram_axi_top.sv ====
/*
 AXI4 memory slave over a 4 KiB byte-writable RAM
 separate write and read paths, FIXED / INCR / WRAP bursts up to 16 beats
 */
`timescale 1ns/1ps
`include "ram_axi_defines.svh"

module ram_axi_top
    import axi_burst_pkg::*;
    import ram_mem_pkg::*;
(
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,

    input  axi_id_t    s_axi_awid,
    input  axi_addr_t  s_axi_awaddr,
    input  axi_len_t   s_axi_awlen,
    input  axi_burst_e s_axi_awburst,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,

    input  mem_word_u  s_axi_wdata,
    input  strb_t      s_axi_wstrb,
    input  logic       s_axi_wlast,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,

    output axi_id_t    s_axi_bid,
    output axi_resp_e  s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,

    input  axi_id_t    s_axi_arid,
    input  axi_addr_t  s_axi_araddr,
    input  axi_len_t   s_axi_arlen,
    input  axi_burst_e s_axi_arburst,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,

    output axi_id_t    s_axi_rid,
    output mem_word_u  s_axi_rdata,
    output axi_resp_e  s_axi_rresp,
    output logic       s_axi_rlast,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready
);

    // write stage to array
    logic      wr_en;
    word_idx_t wr_idx;
    strb_t     wr_strb;
    mem_word_u wr_data;

    // read stage to array
    logic      rd_en;
    word_idx_t rd_idx;
    mem_word_u rd_data;

    assign s_axi_bresp = RESP_OKAY;  // no error cases
    assign s_axi_rresp = RESP_OKAY;

    ram_write_stage u_wr (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awid          (s_axi_awid),
        .awaddr        (s_axi_awaddr),
        .awlen         (s_axi_awlen),
        .awburst       (s_axi_awburst),
        .awvalid       (s_axi_awvalid),
        .awready       (s_axi_awready),
        .wdata         (s_axi_wdata),
        .wstrb         (s_axi_wstrb),
        .wlast         (s_axi_wlast),
        .wvalid        (s_axi_wvalid),
        .wready        (s_axi_wready),
        .bid           (s_axi_bid),
        .bvalid        (s_axi_bvalid),
        .bready        (s_axi_bready),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_strb       (wr_strb),
        .wr_data       (wr_data)
    );

    ram_read_stage u_rd (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .arid          (s_axi_arid),
        .araddr        (s_axi_araddr),
        .arlen         (s_axi_arlen),
        .arburst       (s_axi_arburst),
        .arvalid       (s_axi_arvalid),
        .arready       (s_axi_arready),
        .rid           (s_axi_rid),
        .rdata         (s_axi_rdata),
        .rlast         (s_axi_rlast),
        .rvalid        (s_axi_rvalid),
        .rready        (s_axi_rready),
        .rd_en         (rd_en),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data)
    );

    ram_byte_array u_mem (
        .S_AXI_ACLK (S_AXI_ACLK),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_strb    (wr_strb),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_idx     (rd_idx),
        .rd_data    (rd_data)
    );

endmodule

// ==== hdl/ram_read_stage.sv ====
/*
 AXI4 read path, one burst at a time
 issues RAM reads ahead and keeps up to two beats in an output buffer
 so R back-pressure never drops or repeats a beat
 */
`timescale 1ns/1ps
`include "ram_axi_defines.svh"

module ram_read_stage
    import axi_burst_pkg::*;
    import ram_mem_pkg::*;
(
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,
    input  axi_id_t    arid,
    input  axi_addr_t  araddr,
    input  axi_len_t   arlen,
    input  axi_burst_e arburst,
    input  logic       arvalid,
    output logic       arready,
    output axi_id_t    rid,
    output mem_word_u  rdata,
    output logic       rlast,
    output logic       rvalid,
    input  logic       rready,
    output logic       rd_en,
    output word_idx_t  rd_idx,
    input  mem_word_u  rd_data
);

    logic       busy_q;
    logic       issue_done_q;   // all len+1 reads issued
    axi_id_t    id_q;
    axi_len_t   len_q;
    axi_len_t   issue_cnt_q;
    logic       pend_q;         // read in flight, data back next edge
    logic       pend_last_q;
    mem_word_u  buf_data [2];
    logic       buf_last [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic [1:0] credit_used;
    logic       ar_fire;
    logic       r_fire;
    logic       issue_last;

    assign arready = !busy_q;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // entries held + read in flight, minus the beat leaving now
    assign credit_used = count_q + {1'b0, pend_q} - {1'b0, r_fire};
    assign issue_last  = (issue_cnt_q == len_q);
    assign rd_en       = busy_q && !issue_done_q && (credit_used < 2'd2);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            busy_q       <= 1'b0;
            issue_done_q <= 1'b0;
            issue_cnt_q  <= '0;
            pend_q       <= 1'b0;
            wr_ptr_q     <= 1'b0;
            rd_ptr_q     <= 1'b0;
            count_q      <= '0;
        end else begin
            pend_q <= rd_en;
            if (ar_fire) begin
                busy_q       <= 1'b1;
                issue_done_q <= 1'b0;
                issue_cnt_q  <= '0;
            end else if (r_fire && rlast) begin
                busy_q <= 1'b0;  // arready back next cycle
            end
            if (rd_en) begin
                issue_cnt_q <= issue_cnt_q + 1'b1;
                if (issue_last) issue_done_q <= 1'b1;
            end
            if (pend_q) wr_ptr_q <= ~wr_ptr_q;
            if (r_fire) rd_ptr_q <= ~rd_ptr_q;
            count_q <= count_q + {1'b0, pend_q} - {1'b0, r_fire};
        end
    end

    // burst fields and the buffer payload
    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_fire) begin
            id_q  <= arid;
            len_q <= arlen;
        end
        pend_last_q <= issue_last;  // tag travels with the read
        if (pend_q) begin
            buf_data[wr_ptr_q] <= rd_data;
            buf_last[wr_ptr_q] <= pend_last_q;
        end
    end

    burst_addr_gen u_addr (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .load          (ar_fire),
        .start         (araddr),
        .len           (arlen),
        .kind          (arburst),
        .step          (rd_en),
        .idx           (rd_idx)
    );

    assign rvalid = (count_q != 2'd0);
    assign rdata  = buf_data[rd_ptr_q];
    assign rlast  = buf_last[rd_ptr_q];
    assign rid    = id_q;

endmodule

// ==== hdl/ram_write_stage.sv ====
/*
 AXI4 write path, one burst at a time
 takes AW, writes every W beat into the RAM, answers on B
 */
`timescale 1ns/1ps
`include "ram_axi_defines.svh"

module ram_write_stage
    import axi_burst_pkg::*;
    import ram_mem_pkg::*;
(
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,
    input  axi_id_t    awid,
    input  axi_addr_t  awaddr,
    input  axi_len_t   awlen,
    input  axi_burst_e awburst,
    input  logic       awvalid,
    output logic       awready,
    input  mem_word_u  wdata,
    input  strb_t      wstrb,
    input  logic       wlast,
    input  logic       wvalid,
    output logic       wready,
    output axi_id_t    bid,
    output logic       bvalid,
    input  logic       bready,
    output logic       wr_en,
    output word_idx_t  wr_idx,
    output strb_t      wr_strb,
    output mem_word_u  wr_data
);

    typedef enum logic [1:0] {
        WS_IDLE,
        WS_DATA,
        WS_RESP
    } wr_state_e;

    wr_state_e state_q;
    axi_id_t   id_q;
    axi_len_t  len_q;
    axi_len_t  beat_q;   // beats taken so far, stops at len
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;
    logic      gen_step;
    word_idx_t gen_idx;

    assign awready = (state_q == WS_IDLE);
    assign wready  = (state_q == WS_DATA);
    assign bvalid  = (state_q == WS_RESP);
    assign bid     = id_q;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    // address only advances up to beat len, wlast ends the burst
    assign gen_step = w_fire && (beat_q != len_q);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state_q <= WS_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                WS_IDLE: begin
                    if (aw_fire) begin
                        state_q <= WS_DATA;
                        beat_q  <= '0;
                    end
                end
                WS_DATA: begin
                    if (gen_step) beat_q <= beat_q + 1'b1;
                    if (w_fire && wlast) state_q <= WS_RESP;
                end
                WS_RESP: begin
                    if (b_fire) state_q <= WS_IDLE;
                end
                default: state_q <= WS_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_fire) begin
            id_q  <= awid;
            len_q <= awlen;
        end
    end

    burst_addr_gen u_addr (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .load          (aw_fire),
        .start         (awaddr),
        .len           (awlen),
        .kind          (awburst),
        .step          (gen_step),
        .idx           (gen_idx)
    );

    // beat goes to the array on the same edge
    assign wr_en   = w_fire;
    assign wr_idx  = gen_idx;
    assign wr_strb = wstrb;
    assign wr_data = wdata;

endmodule

// ==== hdl/ram_byte_array.sv ====
/*
 word-wide block RAM with byte lane writes
 one write port, one registered read port
 */
`timescale 1ns/1ps
`include "ram_axi_defines.svh"

module ram_byte_array
    import ram_mem_pkg::*;
(
    input  logic      S_AXI_ACLK,
    input  logic      wr_en,
    input  word_idx_t wr_idx,
    input  strb_t     wr_strb,
    input  mem_word_u wr_data,
    input  logic      rd_en,
    input  word_idx_t rd_idx,
    output mem_word_u rd_data
);

    localparam int WORDS = 1 << `RAM_WORDS_LOG2;

    mem_word_u mem [WORDS];

    always_ff @(posedge S_AXI_ACLK) begin
        if (wr_en) begin
            // unstrobed lanes keep their old byte
            for (int lane = 0; lane < `AXI_STRB_W; lane++) begin
                if (wr_strb[lane]) begin
                    mem[wr_idx].bytes[lane] <= wr_data.bytes[lane];
                end
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];  // valid one cycle after rd_en
        end
    end

endmodule

// ==== hdl/burst_addr_gen.sv ====
/*
 burst address generator
 holds the word index of the running burst and steps it
 by the FIXED, INCR and WRAP rules
 */
`timescale 1ns/1ps
`include "ram_axi_defines.svh"

module burst_addr_gen
    import axi_burst_pkg::*;
    import ram_mem_pkg::*;
(
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,
    input  logic       load,
    input  axi_addr_t  start,
    input  axi_len_t   len,
    input  axi_burst_e kind,
    input  logic       step,
    output word_idx_t  idx
);

    localparam int LANE_BITS = $clog2(`AXI_STRB_W);

    word_idx_t  idx_q;
    word_idx_t  wrap_mask_q;  // index bits that move inside the wrap block
    axi_burst_e kind_q;
    word_idx_t  idx_inc;
    word_idx_t  idx_next;

    assign idx_inc = idx_q + 1'b1;

    always_comb begin
        case (kind_q)
            BURST_FIXED: idx_next = idx_q;
            // upper bits stay, low bits count round inside the block
            BURST_WRAP:  idx_next = (idx_q & ~wrap_mask_q) | (idx_inc & wrap_mask_q);
            default:     idx_next = idx_inc;  // INCR and reserved
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            idx_q       <= '0;
            wrap_mask_q <= '0;
            kind_q      <= BURST_INCR;
        end else if (load) begin
            // upper address bits alias
            idx_q       <= start[`RAM_WORDS_LOG2+LANE_BITS-1:LANE_BITS];
            wrap_mask_q <= word_idx_t'(len & axi_len_t'(`BURST_MAX_LEN));
            kind_q      <= kind;
        end else if (step) begin
            idx_q <= idx_next;
        end
    end

    assign idx = idx_q;

endmodule

// ==== hdl/ram_mem_pkg.sv ====
/*
 memory-side types of the AXI4 RAM slave
 word index, lane enables and the byte/word view of a data word
 */
`include "ram_axi_defines.svh"

package ram_mem_pkg;

    typedef logic [`RAM_WORDS_LOG2-1:0] word_idx_t;
    typedef logic [`AXI_STRB_W-1:0]     strb_t;

    // one data word, seen whole or lane by lane
    typedef union packed {
        logic [`AXI_DATA_W-1:0]       word;
        logic [`AXI_STRB_W-1:0][7:0]  bytes;
    } mem_word_u;

endpackage

// ==== hdl/axi_burst_pkg.sv ====
/*
 bus-side types of the AXI4 RAM slave
 burst kind, response code, id, length and byte address
 */
`include "ram_axi_defines.svh"

package axi_burst_pkg;

    // AxBURST encoding, 2'b11 is reserved and handled as INCR
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef logic [`AXI_ID_W-1:0]   axi_id_t;
    typedef logic [7:0]             axi_len_t;   // beats minus one
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

endpackage

// ==== hdl/ram_axi_defines.svh ====
/*
 shared widths and sizes for the AXI4 RAM slave
 bus fields and RAM geometry
 */
`ifndef RAM_AXI_DEFINES_SVH
`define RAM_AXI_DEFINES_SVH

`define AXI_ID_W        4   // transaction id bits
`define AXI_ADDR_W      16  // byte address bits
`define AXI_DATA_W      32  // full 32-bit beats only
`define AXI_STRB_W      4   // byte lanes per beat

// 1024 words of 4 bytes, 4 KiB
`define RAM_WORDS_LOG2  10

`define BURST_MAX_LEN   15  // len field, 16 beats

`endif
